/* rtl/upRegPkg.sv */
// ==============================
// upload register block shared definitions:
// register map, field bit positions, widths
// and descriptor structs
// ==============================

`default_nettype none

package upRegPkg;

    // ==============================
    // widths
    // ==============================
    localparam int REG_ADDR_W = 16;  // host register offset
    localparam int REG_DATA_W = 32;  // host data word
    localparam int BUF_ADDR_W = 64;  // host memory address
    localparam int BUF_SIZE_W = 24;  // buffer size in bytes
    localparam int DCNT_W     = 9;   // empty-buffer data count

    typedef logic [REG_ADDR_W-1:0] regAddr_t;
    typedef logic [REG_DATA_W-1:0] regData_t;
    typedef logic [BUF_ADDR_W-1:0] bufAddr_t;
    typedef logic [BUF_SIZE_W-1:0] bufSize_t;
    typedef logic [DCNT_W-1:0]     dataCnt_t;

    // ==============================
    // register map
    // ==============================
    localparam int NUM_CHAN = 2;

    localparam regAddr_t CHAN0_BASE = 16'h0000;
    localparam regAddr_t CHAN1_BASE = 16'h1000;
    localparam regAddr_t CHAN_BASE [NUM_CHAN] = '{CHAN0_BASE, CHAN1_BASE};

    // offsets inside one channel window
    localparam regAddr_t EB0_OFS = 16'h0000;  // ebuf addr low
    localparam regAddr_t EB1_OFS = 16'h0008;  // ebuf addr high
    localparam regAddr_t EB2_OFS = 16'h0010;  // ebuf size, auto, cmds
    localparam regAddr_t EB3_OFS = 16'h0018;  // ebuf data count, ro
    localparam regAddr_t FB0_OFS = 16'h0100;  // fbuf addr low
    localparam regAddr_t FB1_OFS = 16'h0108;  // fbuf addr high
    localparam regAddr_t FB2_OFS = 16'h0110;  // fbuf size, trig

    // write data command and flag bits
    localparam int TRIG_BIT    = 24;
    localparam int REQ_BIT     = 25;
    localparam int AUTO_WR_BIT = 26;

    // auto flag sits lower on readback than on write
    localparam int AUTO_RD_BIT = 24;

    // ==============================
    // types
    // ==============================
    typedef enum logic [2:0] {
        ebAddrLo = 3'd0,
        ebAddrHi = 3'd1,
        ebCtrl   = 3'd2,
        ebCount  = 3'd3,
        fbAddrLo = 3'd4,
        fbAddrHi = 3'd5,
        fbCtrl   = 3'd6
    } regIdx_e;

    // one captured host access, as seen by one channel
    typedef struct packed {
        logic     hit;     // request captured and address in this channel
        logic     write;   // clear for a read
        regIdx_e  regIdx;
        regData_t wdata;
    } chanAccess_t;

    typedef struct packed {
        bufAddr_t addr;
        bufSize_t size;
        logic     auto;    // automatic empty-buffer read
    } ebufDesc_t;

    typedef struct packed {
        bufAddr_t addr;
        bufSize_t size;
    } fbufDesc_t;

    // single-cycle command strobes
    typedef struct packed {
        logic ebufRdReq;
        logic ebufRdTrig;
        logic fbufWrTrig;
    } chanPulse_t;

endpackage

`default_nettype wire

/* rtl/upRegCmdCapture.sv */
// ==============================
// host request capture stage and address
// decode into per-channel accesses
// ==============================

`timescale 1ns/1ps
`default_nettype none

module upRegCmdCapture (
    input  wire logic                   PCIE_CLK,
    input  wire logic                   PCIE_RST,
    input  wire logic                   regWrReq,
    input  wire logic                   regRdReq,
    input  wire upRegPkg::regAddr_t     regOpAddr,
    input  wire upRegPkg::regData_t     regWrData,
    output upRegPkg::chanAccess_t       chan0Acc,
    output upRegPkg::chanAccess_t       chan1Acc,
    output logic                        capWr,
    output logic                        capRd
);

    upRegPkg::regAddr_t    capAddr;                     // held address of last request
    upRegPkg::regData_t    capData;                     // held write data
    upRegPkg::chanAccess_t accArr [upRegPkg::NUM_CHAN];

    // ==============================
    // input registers
    // ==============================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            capWr <= 1'b0;
            capRd <= 1'b0;
        end else begin
            capWr <= regWrReq;                          // one-cycle strobes
            capRd <= regRdReq;
        end
    end

    always_ff @(posedge PCIE_CLK) begin
        if (regWrReq || regRdReq) begin
            capAddr <= regOpAddr;
        end
        if (regWrReq) begin
            capData <= regWrData;
        end
    end

    // ==============================
    // address decode
    // ==============================

    // map the captured address onto one channel window
    function automatic upRegPkg::chanAccess_t buildAccess(
        input upRegPkg::regAddr_t base
    );
        upRegPkg::chanAccess_t a;
        upRegPkg::regAddr_t    ofs;
        logic                  mapped;

        a      = '0;
        ofs    = capAddr - base;                        // wraps out of range below base
        mapped = 1'b1;
        case (ofs)
            upRegPkg::EB0_OFS: a.regIdx = upRegPkg::ebAddrLo;
            upRegPkg::EB1_OFS: a.regIdx = upRegPkg::ebAddrHi;
            upRegPkg::EB2_OFS: a.regIdx = upRegPkg::ebCtrl;
            upRegPkg::EB3_OFS: a.regIdx = upRegPkg::ebCount;
            upRegPkg::FB0_OFS: a.regIdx = upRegPkg::fbAddrLo;
            upRegPkg::FB1_OFS: a.regIdx = upRegPkg::fbAddrHi;
            upRegPkg::FB2_OFS: a.regIdx = upRegPkg::fbCtrl;
            default:           mapped   = 1'b0;
        endcase
        a.hit   = mapped && (capWr || capRd);
        a.write = capWr;
        a.wdata = capData;
        return a;
    endfunction

    always_comb begin
        for (int c = 0; c < upRegPkg::NUM_CHAN; c++) begin
            accArr[c] = buildAccess(upRegPkg::CHAN_BASE[c]);
        end
    end

    assign chan0Acc = accArr[0];
    assign chan1Acc = accArr[1];

endmodule

`default_nettype wire

/* rtl/upChannelRegs.sv */
// ==============================
// one upload channel: descriptor registers,
// command pulses, data count sampling
// and readback word
// ==============================

`timescale 1ns/1ps
`default_nettype none

module upChannelRegs (
    input  wire logic                   PCIE_CLK,
    input  wire logic                   PCIE_RST,
    input  wire upRegPkg::chanAccess_t  acc,
    input  wire upRegPkg::dataCnt_t     ebufWrDcnt,
    output upRegPkg::ebufDesc_t         ebufDesc,
    output upRegPkg::fbufDesc_t         fbufDesc,
    output upRegPkg::chanPulse_t        pulse,
    output upRegPkg::regData_t          rdWord
);

    localparam int HALF_W = upRegPkg::REG_DATA_W;

    logic               wrHit;
    logic               rdHit;
    logic               ebCtrlWr;
    logic               fbCtrlWr;
    upRegPkg::dataCnt_t dcntQ;                          // sampled data count

    assign wrHit    = acc.hit && acc.write;
    assign rdHit    = acc.hit && !acc.write;
    assign ebCtrlWr = wrHit && (acc.regIdx == upRegPkg::ebCtrl);
    assign fbCtrlWr = wrHit && (acc.regIdx == upRegPkg::fbCtrl);

    // ==============================
    // descriptor registers
    // ==============================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            ebufDesc <= '0;
            fbufDesc <= '0;
        end else if (wrHit) begin
            case (acc.regIdx)
                upRegPkg::ebAddrLo: begin
                    ebufDesc.addr[HALF_W-1:0] <= acc.wdata;
                end
                upRegPkg::ebAddrHi: begin
                    ebufDesc.addr[2*HALF_W-1:HALF_W] <= acc.wdata;
                end
                upRegPkg::ebCtrl: begin
                    ebufDesc.size <= acc.wdata[upRegPkg::BUF_SIZE_W-1:0];
                    ebufDesc.auto <= acc.wdata[upRegPkg::AUTO_WR_BIT];
                end
                upRegPkg::fbAddrLo: begin
                    fbufDesc.addr[HALF_W-1:0] <= acc.wdata;
                end
                upRegPkg::fbAddrHi: begin
                    fbufDesc.addr[2*HALF_W-1:HALF_W] <= acc.wdata;
                end
                upRegPkg::fbCtrl: begin
                    fbufDesc.size <= acc.wdata[upRegPkg::BUF_SIZE_W-1:0];
                end
                default: begin
                    // count register is read only
                end
            endcase
        end
    end

    // ==============================
    // command pulses
    // ==============================

    // access lasts one cycle, so each pulse does too
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            pulse <= '0;
        end else begin
            pulse.ebufRdReq  <= ebCtrlWr && acc.wdata[upRegPkg::REQ_BIT];
            pulse.ebufRdTrig <= ebCtrlWr && acc.wdata[upRegPkg::TRIG_BIT];
            pulse.fbufWrTrig <= fbCtrlWr && acc.wdata[upRegPkg::TRIG_BIT];
        end
    end

    // data count sampled every cycle
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            dcntQ <= '0;
        end else begin
            dcntQ <= ebufWrDcnt;
        end
    end

    // ==============================
    // readback
    // ==============================
    always_comb begin
        rdWord = '0;                                    // zero fill, zero when idle
        if (rdHit) begin
            case (acc.regIdx)
                upRegPkg::ebAddrLo: rdWord = ebufDesc.addr[HALF_W-1:0];
                upRegPkg::ebAddrHi: rdWord = ebufDesc.addr[2*HALF_W-1:HALF_W];
                upRegPkg::ebCtrl: begin
                    rdWord[upRegPkg::BUF_SIZE_W-1:0] = ebufDesc.size;
                    rdWord[upRegPkg::AUTO_RD_BIT]    = ebufDesc.auto;
                end
                upRegPkg::ebCount:  rdWord[upRegPkg::DCNT_W-1:0] = dcntQ;
                upRegPkg::fbAddrLo: rdWord = fbufDesc.addr[HALF_W-1:0];
                upRegPkg::fbAddrHi: rdWord = fbufDesc.addr[2*HALF_W-1:HALF_W];
                upRegPkg::fbCtrl:   rdWord[upRegPkg::BUF_SIZE_W-1:0] = fbufDesc.size;
                default:            rdWord = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/upRegReadPort.sv */
// ==============================
// read data merge, registered read data
// and write/read acknowledges
// ==============================

`timescale 1ns/1ps
`default_nettype none

module upRegReadPort (
    input  wire logic                   PCIE_CLK,
    input  wire logic                   PCIE_RST,
    input  wire logic                   capWr,
    input  wire logic                   capRd,
    input  wire upRegPkg::regData_t     chan0Word,
    input  wire upRegPkg::regData_t     chan1Word,
    output upRegPkg::regData_t          regRdData,
    output logic                        regWrAck,
    output logic                        regRdAck
);

    upRegPkg::regData_t mergedWord;

    // only the addressed channel drives a nonzero word
    assign mergedWord = chan0Word | chan1Word;

    // ==============================
    // read data and acks
    // ==============================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            regRdData <= '0;
        end else if (capRd) begin
            regRdData <= mergedWord;                    // held until next read
        end
    end

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            regWrAck <= 1'b0;
            regRdAck <= 1'b0;
        end else begin
            regWrAck <= capWr;                          // unmapped writes acked too
            regRdAck <= capRd;                          // same cycle as read data
        end
    end

endmodule

`default_nettype wire

/* rtl/upRegTop.sv */
// ==============================
// upload register block top level:
// capture stage, two channel banks, read port
// ==============================

`timescale 1ns/1ps
`default_nettype none

module upRegTop (
    input  wire logic                   PCIE_CLK,
    input  wire logic                   PCIE_RST,
    // host register port
    input  wire logic                   regWrReq,
    input  wire logic                   regRdReq,
    input  wire upRegPkg::regAddr_t     regOpAddr,
    input  wire upRegPkg::regData_t     regWrData,
    output upRegPkg::regData_t          regRdData,
    output logic                        regWrAck,
    output logic                        regRdAck,
    // channel side
    input  wire upRegPkg::dataCnt_t     up0EbufWrDcnt,
    input  wire upRegPkg::dataCnt_t     up1EbufWrDcnt,
    output upRegPkg::ebufDesc_t         up0Ebuf,
    output upRegPkg::ebufDesc_t         up1Ebuf,
    output upRegPkg::fbufDesc_t         up0Fbuf,
    output upRegPkg::fbufDesc_t         up1Fbuf,
    output upRegPkg::chanPulse_t        up0Pulse,
    output upRegPkg::chanPulse_t        up1Pulse
);

    upRegPkg::chanAccess_t chan0Acc;
    upRegPkg::chanAccess_t chan1Acc;
    upRegPkg::regData_t    chan0Word;
    upRegPkg::regData_t    chan1Word;
    logic                  capWr;
    logic                  capRd;

    // ==============================
    // request capture
    // ==============================
    upRegCmdCapture u_capture (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .regWrReq  (regWrReq),
        .regRdReq  (regRdReq),
        .regOpAddr (regOpAddr),
        .regWrData (regWrData),
        .chan0Acc  (chan0Acc),
        .chan1Acc  (chan1Acc),
        .capWr     (capWr),
        .capRd     (capRd)
    );

    // ==============================
    // channel banks
    // ==============================
    upChannelRegs u_chan0 (
        .PCIE_CLK   (PCIE_CLK),
        .PCIE_RST   (PCIE_RST),
        .acc        (chan0Acc),
        .ebufWrDcnt (up0EbufWrDcnt),
        .ebufDesc   (up0Ebuf),
        .fbufDesc   (up0Fbuf),
        .pulse      (up0Pulse),
        .rdWord     (chan0Word)
    );

    upChannelRegs u_chan1 (
        .PCIE_CLK   (PCIE_CLK),
        .PCIE_RST   (PCIE_RST),
        .acc        (chan1Acc),
        .ebufWrDcnt (up1EbufWrDcnt),
        .ebufDesc   (up1Ebuf),
        .fbufDesc   (up1Fbuf),
        .pulse      (up1Pulse),
        .rdWord     (chan1Word)
    );

    // read data and acks
    upRegReadPort u_readPort (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .capWr     (capWr),
        .capRd     (capRd),
        .chan0Word (chan0Word),
        .chan1Word (chan1Word),
        .regRdData (regRdData),
        .regWrAck  (regWrAck),
        .regRdAck  (regRdAck)
    );

endmodule

`default_nettype wire

/* tb/upReg_chk.sv */
// ==============================
// register port protocol and
// command pulse assertions
// ==============================

`timescale 1ns/1ps
`default_nettype none

module upReg_chk (
    input wire logic                 PCIE_CLK,
    input wire logic                 PCIE_RST,
    input wire logic                 regWrReq,
    input wire logic                 regRdReq,
    input wire logic                 regWrAck,
    input wire logic                 regRdAck,
    input wire upRegPkg::chanPulse_t up0Pulse,
    input wire upRegPkg::chanPulse_t up1Pulse
);

    ackExclusive: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        !(regWrAck && regRdAck))
        else $error("write and read acknowledge high together");

    // capture edge plus register edge, ack only for its own request
    wrAckLatency: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        regWrAck == $past(regWrReq, 2))
        else $error("write acknowledge not exactly two edges after a request");

    rdAckLatency: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        regRdAck == $past(regRdReq, 2))
        else $error("read acknowledge not exactly two edges after a request");

    pulseOneCycle: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        ({up0Pulse, up1Pulse} & $past({up0Pulse, up1Pulse})) == '0)
        else $error("command pulse longer than one cycle");

endmodule

bind upRegTop upReg_chk u_chk (.*);

`default_nettype wire

/* tb/upRegTb.sv */
// ==============================
// upload register block testbench:
// random register traffic, reference model, checks
// ==============================

`timescale 1ns/1ps
`default_nettype none

module upRegTb;

    localparam int NUM_REGS    = 7;
    localparam int ACK_TIMEOUT = 20;                    // cycles

    logic                 PCIE_CLK;
    logic                 PCIE_RST;
    logic                 regWrReq;
    logic                 regRdReq;
    upRegPkg::regAddr_t   regOpAddr;
    upRegPkg::regData_t   regWrData;
    upRegPkg::regData_t   regRdData;
    logic                 regWrAck;
    logic                 regRdAck;
    upRegPkg::dataCnt_t   dcnt [2];                     // driven data counts
    upRegPkg::ebufDesc_t  up0Ebuf;
    upRegPkg::ebufDesc_t  up1Ebuf;
    upRegPkg::fbufDesc_t  up0Fbuf;
    upRegPkg::fbufDesc_t  up1Fbuf;
    upRegPkg::chanPulse_t up0Pulse;
    upRegPkg::chanPulse_t up1Pulse;
    integer               seed;

    // reference model of both channels
    upRegPkg::bufAddr_t   mEbAddr [2];
    upRegPkg::bufSize_t   mEbSize [2];
    logic                 mEbAuto [2];
    upRegPkg::bufAddr_t   mFbAddr [2];
    upRegPkg::bufSize_t   mFbSize [2];

    upRegTop u_dut (
        .PCIE_CLK      (PCIE_CLK),
        .PCIE_RST      (PCIE_RST),
        .regWrReq      (regWrReq),
        .regRdReq      (regRdReq),
        .regOpAddr     (regOpAddr),
        .regWrData     (regWrData),
        .regRdData     (regRdData),
        .regWrAck      (regWrAck),
        .regRdAck      (regRdAck),
        .up0EbufWrDcnt (dcnt[0]),
        .up1EbufWrDcnt (dcnt[1]),
        .up0Ebuf       (up0Ebuf),
        .up1Ebuf       (up1Ebuf),
        .up0Fbuf       (up0Fbuf),
        .up1Fbuf       (up1Fbuf),
        .up0Pulse      (up0Pulse),
        .up1Pulse      (up1Pulse)
    );

    initial begin
        PCIE_CLK = 1'b0;
        forever #4 PCIE_CLK = ~PCIE_CLK;                // 8 ns period
    end

    // ==============================
    // checks and bus tasks
    // ==============================
    task automatic compareValue(input string name, input logic [95:0] exp,
                                input logic [95:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic waitAck(input logic isWrite);
        int cnt;
        cnt = 0;
        while (!(isWrite ? regWrAck : regRdAck)) begin
            @(negedge PCIE_CLK);
            cnt++;
            if (cnt > ACK_TIMEOUT) begin
                $display("no %s acknowledge arrived in time", isWrite ? "write" : "read");
                $display("TEST RESULT: FAIL");
                $fatal(1, "acknowledge timeout");
            end
        end
    endtask

    task automatic busWrite(input upRegPkg::regAddr_t addr, input upRegPkg::regData_t data);
        @(negedge PCIE_CLK);
        regWrReq  = 1'b1;                               // one-cycle request
        regOpAddr = addr;
        regWrData = data;
        @(negedge PCIE_CLK);
        regWrReq  = 1'b0;
        waitAck(1'b1);
    endtask

    task automatic busRead(input upRegPkg::regAddr_t addr, output upRegPkg::regData_t data);
        @(negedge PCIE_CLK);
        regRdReq  = 1'b1;
        regOpAddr = addr;
        @(negedge PCIE_CLK);
        regRdReq  = 1'b0;
        waitAck(1'b0);
        data = regRdData;                               // valid with the ack
    endtask

    // ==============================
    // register map and model rules
    // ==============================
    function automatic upRegPkg::regAddr_t chanBase(input int c);
        return (c == 0) ? 16'h0000 : 16'h1000;
    endfunction

    function automatic upRegPkg::regAddr_t regOffset(input int r);
        case (r)
            0:       return 16'h0000;
            1:       return 16'h0008;
            2:       return 16'h0010;
            3:       return 16'h0018;
            4:       return 16'h0100;
            5:       return 16'h0108;
            default: return 16'h0110;
        endcase
    endfunction

    function automatic logic isMapped(input upRegPkg::regAddr_t a);
        logic m;
        m = 1'b0;
        for (int c = 0; c < 2; c++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (a == chanBase(c) + regOffset(r)) begin
                    m = 1'b1;
                end
            end
        end
        return m;
    endfunction

    function automatic upRegPkg::regData_t expectedRead(input int c, input int r);
        upRegPkg::regData_t w;
        w = '0;
        case (r)
            0: w = mEbAddr[c][31:0];
            1: w = mEbAddr[c][63:32];
            2: begin
                w[23:0] = mEbSize[c];
                w[24]   = mEbAuto[c];                   // written at bit 26
            end
            3: w[8:0] = dcnt[c];
            4: w = mFbAddr[c][31:0];
            5: w = mFbAddr[c][63:32];
            default: w[23:0] = mFbSize[c];
        endcase
        return w;
    endfunction

    // order: ebuf request, ebuf trigger, fbuf trigger
    function automatic logic [2:0] expectedPulse(input int r, input upRegPkg::regData_t d);
        if (r == 2) begin
            return {d[25], d[24], 1'b0};
        end else if (r == 6) begin
            return {2'b00, d[24]};
        end
        return 3'b000;
    endfunction

    task automatic modelWrite(input int c, input int r, input upRegPkg::regData_t d);
        case (r)
            0: mEbAddr[c][31:0]  = d;
            1: mEbAddr[c][63:32] = d;
            2: begin
                mEbSize[c] = d[23:0];
                mEbAuto[c] = d[26];
            end
            4: mFbAddr[c][31:0]  = d;
            5: mFbAddr[c][63:32] = d;
            6: mFbSize[c] = d[23:0];
            default: ;                                  // count is read only
        endcase
    endtask

    task automatic checkDescriptors(input string name);
        compareValue({name, " ebuf0"}, {mEbAddr[0], mEbSize[0], mEbAuto[0]}, up0Ebuf);
        compareValue({name, " ebuf1"}, {mEbAddr[1], mEbSize[1], mEbAuto[1]}, up1Ebuf);
        compareValue({name, " fbuf0"}, {mFbAddr[0], mFbSize[0]}, up0Fbuf);
        compareValue({name, " fbuf1"}, {mFbAddr[1], mFbSize[1]}, up1Fbuf);
    endtask

    // pulses are checked while the write ack is high
    task automatic writeAndCheck(input string name, input int c, input int r,
                                 input upRegPkg::regData_t d);
        busWrite(chanBase(c) + regOffset(r), d);
        compareValue({name, " pulse0"}, (c == 0) ? expectedPulse(r, d) : 3'b000, up0Pulse);
        compareValue({name, " pulse1"}, (c == 1) ? expectedPulse(r, d) : 3'b000, up1Pulse);
        modelWrite(c, r, d);
        @(negedge PCIE_CLK);                            // descriptors settled one cycle ago
        checkDescriptors(name);
    endtask

    task automatic readAndCheck(input string name, input int c, input int r);
        upRegPkg::regData_t rd;
        busRead(chanBase(c) + regOffset(r), rd);
        compareValue(name, expectedRead(c, r), rd);
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        upRegPkg::regData_t d;
        upRegPkg::regData_t rd;
        upRegPkg::regAddr_t addr;
        int                 c;
        int                 r;

        seed      = 71;
        PCIE_RST  = 1'b1;
        regWrReq  = 1'b0;
        regRdReq  = 1'b0;
        regOpAddr = '0;
        regWrData = '0;
        dcnt[0]   = '0;
        dcnt[1]   = '0;
        for (int k = 0; k < 2; k++) begin
            mEbAddr[k] = '0;
            mEbSize[k] = '0;
            mEbAuto[k] = 1'b0;
            mFbAddr[k] = '0;
            mFbSize[k] = '0;
        end
        repeat (10) @(posedge PCIE_CLK);
        @(negedge PCIE_CLK);
        PCIE_RST = 1'b0;

        // reset values
        dcnt[0] = $random(seed);
        dcnt[1] = $random(seed);
        checkDescriptors("reset");
        compareValue("reset pulses", 6'b0, {up0Pulse, up1Pulse});
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < NUM_REGS; j++) begin
                readAndCheck("reset readback", k, j);
            end
        end

        // random writes with readback
        repeat (200) begin
            c = $unsigned($random(seed)) % 2;
            r = $unsigned($random(seed)) % NUM_REGS;
            d = $random(seed);
            writeAndCheck("random write", c, r, d);
            readAndCheck("random readback", $unsigned($random(seed)) % 2,
                         $unsigned($random(seed)) % NUM_REGS);
        end

        // command pulses on the ctrl registers
        repeat (60) begin
            c = $unsigned($random(seed)) % 2;
            r = ($random(seed) & 1) ? 2 : 6;
            d = $random(seed);
            writeAndCheck("command pulse", c, r, d);
        end

        // data count held for a few cycles, then read
        repeat (20) begin
            @(negedge PCIE_CLK);
            dcnt[0] = $random(seed);
            dcnt[1] = $random(seed);
            repeat (3) @(negedge PCIE_CLK);
            readAndCheck("data count ch0", 0, 3);
            readAndCheck("data count ch1", 1, 3);
        end

        // unmapped addresses
        repeat (40) begin
            addr = $random(seed);
            if (isMapped(addr)) begin
                addr[2] = 1'b1;                         // mapped offsets are 8-aligned
            end
            busWrite(addr, $random(seed));
            compareValue("unmapped pulses", 6'b0, {up0Pulse, up1Pulse});
            @(negedge PCIE_CLK);
            checkDescriptors("unmapped write");
            busRead(addr, rd);
            compareValue("unmapped read", 32'h0, rd);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* upReg.f */
rtl/upRegPkg.sv
rtl/upRegCmdCapture.sv
rtl/upChannelRegs.sv
rtl/upRegReadPort.sv
rtl/upRegTop.sv
tb/upReg_chk.sv
tb/upRegTb.sv

/* Bender.yml */
package:
  name: upReg

sources:
  # register block RTL, package first
  - files:
      - rtl/upRegPkg.sv
      - rtl/upRegCmdCapture.sv
      - rtl/upChannelRegs.sv
      - rtl/upRegReadPort.sv
      - rtl/upRegTop.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/upReg_chk.sv
      - tb/upRegTb.sv
